// ==== hdl/exec_config.svh ====
// Execute stage configuration
// Word width, shift-amount width and the step count of the
// iterative multiply/divide unit. Fixed by the instruction set.

`ifndef EXEC_CONFIG_SVH
`define EXEC_CONFIG_SVH

// data path width
`define EXEC_XLEN      32

// low bits of operand a used as the shift amount
`define EXEC_SHAMT_W   5

// one multiply or divide step per cycle, one per operand bit
`define EXEC_MD_STEPS  32

`endif

// ==== hdl/exec_pkg.sv ====
// Execute stage types
// Operation codes, operand select codes and the packed structs
// that carry control, forwarding and operand words between blocks.

`include "exec_config.svh"

package exec_pkg;

    typedef logic [`EXEC_XLEN-1:0] word_t;

    // operation code from the decoder
    typedef enum logic [4:0]
    {
        OP_NOP   = 5'h00,
        OP_PA    = 5'h01,
        OP_PB    = 5'h02,
        OP_ADD   = 5'h03,
        OP_SUB   = 5'h04,
        OP_SUBU  = 5'h05,
        OP_OR    = 5'h06,
        OP_AND   = 5'h07,
        OP_XOR   = 5'h08,
        OP_NOR   = 5'h09,
        OP_SLT   = 5'h0a,
        OP_SLTU  = 5'h0b,
        OP_SLL   = 5'h0c,
        OP_SRL   = 5'h0d,
        OP_SRA   = 5'h0e,
        OP_MULT  = 5'h0f,
        OP_MULTU = 5'h10,
        OP_DIV   = 5'h11,
        OP_DIVU  = 5'h12,
        OP_MFHI  = 5'h13,
        OP_MFLO  = 5'h14,
        OP_MTHI  = 5'h15,
        OP_MTLO  = 5'h16
    } alu_op_e;

    typedef enum logic [1:0] {FW_NONE = 2'd0, FW_ALU = 2'd1, FW_MEM = 2'd2} fw_sel_e;
    typedef enum logic {MUXA_RS = 1'b0, MUXA_EXT = 1'b1} muxa_sel_e;
    typedef enum logic {MUXB_RT = 1'b0, MUXB_EXT = 1'b1} muxb_sel_e;

    typedef struct packed {
        alu_op_e   op;
        muxa_sel_e muxa;
        muxb_sel_e muxb;
        fw_sel_e   fw_a;    // forwarding for rs
        fw_sel_e   fw_b;    // forwarding for rt
    } exec_ctl_t;

    typedef struct packed {
        word_t alu;         // result leaving the ALU stage
        word_t mem;         // result leaving the memory stage
    } fwd_bus_t;

    typedef struct packed {
        word_t a;
        word_t b;
    } operands_t;

endpackage

// ==== hdl/exec_operand_sel.sv ====
// Operand select
// Resolves forwarding for rs and rt from the ALU and memory stage
// buses, then swaps in the immediate where the decoder asks for it.
// The forwarded rt also leaves as store data.

`timescale 1ns/1ps

module exec_operand_sel
(
    input  exec_pkg::exec_ctl_t ctl_i,
    input  exec_pkg::word_t     rs_i,
    input  exec_pkg::word_t     rt_i,
    input  exec_pkg::word_t     ext_i,
    input  exec_pkg::fwd_bus_t  fwd_i,
    output exec_pkg::operands_t operands_o,
    output exec_pkg::word_t     rt_fwd_o
);

    import exec_pkg::*;

    word_t rs_fwd;
    word_t rt_fwd;

    // pick the freshest copy of a register value
    function automatic word_t fwd_pick
    (
        input fw_sel_e  sel,
        input word_t    reg_val,
        input fwd_bus_t fwd
    );
        case (sel)
            FW_ALU:  return fwd.alu;
            FW_MEM:  return fwd.mem;
            default: return reg_val;    // FW_NONE and unused code
        endcase
    endfunction

    assign rs_fwd = fwd_pick(ctl_i.fw_a, rs_i, fwd_i);
    assign rt_fwd = fwd_pick(ctl_i.fw_b, rt_i, fwd_i);

    always_comb
    begin
        operands_o.a = (ctl_i.muxa == MUXA_EXT) ? ext_i : rs_fwd;
        operands_o.b = (ctl_i.muxb == MUXB_EXT) ? ext_i : rt_fwd;
    end

    assign rt_fwd_o = rt_fwd;       // store data ignores muxb

endmodule

// ==== hdl/exec_alu.sv ====
// Arithmetic and logic unit
// Single-cycle add, subtract, bitwise logic, set-less-than and the
// barrel shifter. The shifted value is operand b, the amount is the
// low bits of operand a. Codes owned by the multiply/divide unit
// produce zero here so the top can or the two results together.

`timescale 1ns/1ps
`include "exec_config.svh"

module exec_alu
(
    input  exec_pkg::alu_op_e   op_i,
    input  exec_pkg::operands_t operands_i,
    output exec_pkg::word_t     result_o
);

    import exec_pkg::*;

    localparam int W = `EXEC_XLEN;

    word_t                   a;
    word_t                   b;
    logic [W:0]              slt_diff;
    logic [`EXEC_SHAMT_W-1:0] shamt;

    assign a     = operands_i.a;
    assign b     = operands_i.b;
    assign shamt = a[`EXEC_SHAMT_W-1:0];

    // sign-extend both sides so the borrow bit is the signed compare
    assign slt_diff = {a[W-1], a} - {b[W-1], b};

    always_comb
    begin
        case (op_i)
            OP_PA:
                result_o = a;
            OP_PB:
                result_o = b;
            OP_ADD:
                result_o = a + b;
            OP_SUB, OP_SUBU:
                result_o = a - b;   // no overflow trap
            OP_OR:
                result_o = a | b;
            OP_AND:
                result_o = a & b;
            OP_XOR:
                result_o = a ^ b;
            OP_NOR:
                result_o = ~(a | b);
            OP_SLT:
                result_o = {{(W-1){1'b0}}, slt_diff[W]};
            OP_SLTU:
                result_o = {{(W-1){1'b0}}, (a < b)};
            OP_SLL:
                result_o = b << shamt;
            OP_SRL:
                result_o = b >> shamt;
            OP_SRA:
                result_o = word_t'($signed(b) >>> shamt);
            default:
                result_o = '0;      // muldiv codes and nop
        endcase
    end

endmodule

// ==== hdl/exec_muldiv.sv ====
// Iterative multiply/divide unit with the hi and lo registers
// One operation at a time, one step per cycle. Signed multiply uses
// a Booth add/shift step, unsigned a plain add/shift. Division runs
// non-restoring on magnitudes, then fixes the remainder and the
// result signs in up to two closing cycles. Ready is low while busy.

`timescale 1ns/1ps
`include "exec_config.svh"

module exec_muldiv
(
    input  logic                clk,
    input  logic                rst,
    input  exec_pkg::alu_op_e   op_i,
    input  exec_pkg::operands_t operands_i,
    output exec_pkg::word_t     result_o,
    output logic                rdy_o
);

    import exec_pkg::*;

    localparam int W     = `EXEC_XLEN;
    localparam int CNT_W = $clog2(`EXEC_MD_STEPS) + 1;

    logic [2*W:0]     hilo;         // {guard, hi, lo}
    logic [W:0]       dvsr;         // divisor magnitude or multiplicand
    logic             a_neg;        // dividend was negative
    logic             b_neg;        // divisor was negative
    logic [CNT_W-1:0] count;
    logic             mul_q;
    logic             sign_q;
    logic             finish_q;     // remainder already restored
    logic             booth_q;      // multiplier bit shifted out last step

    logic             is_mul;
    logic             is_sign;
    logic             start;
    logic             steps_done;
    word_t            a_mag;
    word_t            b_mag;
    logic [W:0]       mul_acc;
    logic [W+1:0]     div_sh;
    logic [W+1:0]     div_nr;
    logic [2*W:0]     step_hilo;

    assign is_mul  = (op_i == OP_MULT) || (op_i == OP_MULTU);
    assign is_sign = (op_i == OP_MULT) || (op_i == OP_DIV);
    assign start   = rdy_o && (is_mul || (op_i == OP_DIV) || (op_i == OP_DIVU));

    assign a_mag = (is_sign && operands_i.a[W-1]) ? -operands_i.a : operands_i.a;
    assign b_mag = (is_sign && operands_i.b[W-1]) ? -operands_i.b : operands_i.b;

    assign steps_done = (count == CNT_W'(`EXEC_MD_STEPS));

    // next working register for one step
    always_comb
    begin
        if (sign_q)
        begin
            case ({hilo[0], booth_q})
                2'b10:   mul_acc = hilo[2*W:W] - dvsr;
                2'b01:   mul_acc = hilo[2*W:W] + dvsr;
                default: mul_acc = hilo[2*W:W];
            endcase
        end
        else if (hilo[0])
        begin
            mul_acc = hilo[2*W:W] + dvsr;
        end
        else
        begin
            mul_acc = hilo[2*W:W];
        end

        // partial remainder shifted left with the next dividend bit
        div_sh = {hilo[2*W:W], hilo[W-1]};
        div_nr = hilo[2*W] ? div_sh + {1'b0, dvsr} : div_sh - {1'b0, dvsr};

        if (mul_q)
            step_hilo = {sign_q & mul_acc[W], mul_acc, hilo[W-1:1]};
        else
            step_hilo = {div_nr[W:0], hilo[W-2:0], ~div_nr[W+1]};
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            hilo     <= '0;
            rdy_o    <= 1'b1;
            count    <= '0;
            mul_q    <= 1'b0;
            sign_q   <= 1'b0;
            finish_q <= 1'b0;
            booth_q  <= 1'b0;
        end
        else if (rdy_o)
        begin
            if (start)
            begin
                hilo     <= {{(W+1){1'b0}}, (is_mul ? operands_i.a : a_mag)};
                rdy_o    <= 1'b0;
                count    <= '0;
                mul_q    <= is_mul;
                sign_q   <= is_sign;
                finish_q <= 1'b0;
                booth_q  <= 1'b0;
            end
            else if (op_i == OP_MTHI)
            begin
                hilo[2*W:W] <= {1'b0, operands_i.a};
            end
            else if (op_i == OP_MTLO)
            begin
                hilo[W-1:0] <= operands_i.a;
            end
        end
        else if (!steps_done)
        begin
            hilo    <= step_hilo;
            booth_q <= hilo[0];
            count   <= count + 1'b1;
        end
        else if (mul_q || finish_q)
        begin
            if (!mul_q)
            begin
                if (a_neg ^ b_neg)
                    hilo[W-1:0] <= -hilo[W-1:0];        // quotient sign
                if (a_neg)
                    hilo[2*W-1:W] <= -hilo[2*W-1:W];    // remainder follows dividend
            end
            rdy_o <= 1'b1;
        end
        else
        begin
            if (hilo[2*W])
                hilo[2*W:W] <= hilo[2*W:W] + dvsr;      // restore negative remainder
            finish_q <= 1'b1;
        end
    end

    // operand copies taken at start
    always_ff @(posedge clk)
    begin
        if (start)
        begin
            dvsr  <= is_mul ? {is_sign & operands_i.b[W-1], operands_i.b} : {1'b0, b_mag};
            a_neg <= is_sign & operands_i.a[W-1];
            b_neg <= is_sign & operands_i.b[W-1];
        end
    end

    always_comb
    begin
        case (op_i)
            OP_MFHI: result_o = hilo[2*W-1:W];
            OP_MFLO: result_o = hilo[W-1:0];
            default: result_o = '0;
        endcase
    end

endmodule

// ==== hdl/exec_stage.sv ====
// Execute stage
// Selects and forwards the operands, runs them through the ALU and
// the multiply/divide unit, and merges the two results. Each unit
// drives zero for codes it does not own. The forwarded rt is passed
// on as store data for the memory stage.

`timescale 1ns/1ps

module exec_stage
(
    input  logic                clk,
    input  logic                rst,
    input  exec_pkg::exec_ctl_t ctl_i,
    input  exec_pkg::word_t     rs_i,
    input  exec_pkg::word_t     rt_i,
    input  exec_pkg::word_t     ext_i,
    input  exec_pkg::fwd_bus_t  fwd_i,
    output exec_pkg::word_t     result_o,
    output exec_pkg::word_t     store_data_o,
    output logic                md_rdy_o
);

    import exec_pkg::*;

    operands_t operands;
    word_t     alu_result;
    word_t     md_result;

    exec_operand_sel u_operand_sel
    (
        .ctl_i      (ctl_i),
        .rs_i       (rs_i),
        .rt_i       (rt_i),
        .ext_i      (ext_i),
        .fwd_i      (fwd_i),
        .operands_o (operands),
        .rt_fwd_o   (store_data_o)
    );

    exec_alu u_alu
    (
        .op_i       (ctl_i.op),
        .operands_i (operands),
        .result_o   (alu_result)
    );

    exec_muldiv u_muldiv
    (
        .clk        (clk),
        .rst        (rst),
        .op_i       (ctl_i.op),
        .operands_i (operands),
        .result_o   (md_result),
        .rdy_o      (md_rdy_o)
    );

    assign result_o = alu_result | md_result;   // at most one unit is non-zero

endmodule

// ==== verification/exec_stage_tb.sv ====
// Execute stage testbench
// Runs the directed cases from verification/exec_cases.txt, then
// random ALU and shift cases checked against a small reference model.
// Multiply/divide cases wait for ready and read hi and lo back.

`timescale 1ns/1ps
`include "exec_config.svh"

module exec_stage_tb;

    import exec_pkg::*;

    localparam int RANDOM_CASES    = 64;
    localparam int CYCLES_PER_CASE = 40;
    localparam int CLK_PERIOD_NS   = 4;

    typedef struct packed {
        exec_ctl_t ctl;
        word_t     rs;
        word_t     rt;
        word_t     ext;
        fwd_bus_t  fwd;
        word_t     exp_a;   // result, or hi for a muldiv start
        word_t     exp_b;   // store data, or lo for a muldiv start
    } case_t;

    logic        clk;
    logic        rst;
    exec_ctl_t   ctl_in;
    word_t       rs_in;
    word_t       rt_in;
    word_t       ext_in;
    fwd_bus_t    fwd_in;
    word_t       result_o;
    word_t       store_data_o;
    logic        md_rdy_o;
    case_t       cases[$];
    logic [31:0] rand_state;
    int          watchdog_ns;

    exec_stage u_exec_stage
    (
        .clk          (clk),
        .rst          (rst),
        .ctl_i        (ctl_in),
        .rs_i         (rs_in),
        .rt_i         (rt_in),
        .ext_i        (ext_in),
        .fwd_i        (fwd_in),
        .result_o     (result_o),
        .store_data_o (store_data_o),
        .md_rdy_o     (md_rdy_o)
    );

    always #2 clk = ~clk;

    task automatic stop_on_error();
        $display("Test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected)
        begin
            $display("[FAIL] %0d ns: %s expected %08h, got %08h", $time, name, expected, actual);
            stop_on_error();
        end
    endtask

    task automatic check_rdy(input string name, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            $display("[FAIL] %0d ns: %s expected %0b, got %0b", $time, name, expected, actual);
            stop_on_error();
        end
    endtask

    function automatic logic [31:0] next_random();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    function automatic logic is_start(input alu_op_e op);
        return (op == OP_MULT) || (op == OP_MULTU) || (op == OP_DIV) || (op == OP_DIVU);
    endfunction

    // reference model of forwarding and the ALU for the random cases
    function automatic word_t expect_store(input case_t c);
        if (c.ctl.fw_b == FW_ALU)
            return c.fwd.alu;
        else if (c.ctl.fw_b == FW_MEM)
            return c.fwd.mem;
        return c.rt;
    endfunction

    function automatic word_t expect_result(input case_t c);
        word_t rs_v;
        word_t a;
        word_t b;
        int    sh;
        rs_v = c.rs;
        if (c.ctl.fw_a == FW_ALU)
            rs_v = c.fwd.alu;
        else if (c.ctl.fw_a == FW_MEM)
            rs_v = c.fwd.mem;
        a  = (c.ctl.muxa == MUXA_EXT) ? c.ext : rs_v;
        b  = (c.ctl.muxb == MUXB_EXT) ? c.ext : expect_store(c);
        sh = int'(a[4:0]);
        case (c.ctl.op)
            OP_ADD:          return a + b;
            OP_SUB, OP_SUBU: return a - b;
            OP_OR:           return a | b;
            OP_AND:          return a & b;
            OP_XOR:          return a ^ b;
            OP_NOR:          return ~(a | b);
            OP_SLL:          return b << sh;
            OP_SRL:          return b >> sh;
            OP_SRA:          return (b >> sh) | (b[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
            default:         return '0;
        endcase
    endfunction

    function automatic case_t make_random_case();
        alu_op_e     ops[10] = '{OP_ADD, OP_SUB, OP_SUBU, OP_OR, OP_AND,
                                 OP_XOR, OP_NOR, OP_SLL, OP_SRL, OP_SRA};
        case_t       c;
        logic [31:0] r;
        r          = next_random();
        c.ctl.op   = ops[r % 10];
        r          = next_random();
        c.ctl.muxa = muxa_sel_e'(r[8]);
        c.ctl.muxb = muxb_sel_e'(r[12]);
        c.ctl.fw_a = fw_sel_e'(2'((r >> 16) % 3));
        c.ctl.fw_b = fw_sel_e'(2'((r >> 20) % 3));
        c.rs       = next_random();
        c.rt       = next_random();
        c.ext      = next_random();
        c.fwd.alu  = next_random();
        c.fwd.mem  = next_random();
        c.exp_a    = expect_result(c);
        c.exp_b    = expect_store(c);
        return c;
    endfunction

    task automatic load_cases();
        int               fd;
        int               got;
        int               n;
        logic [8*256-1:0] line_buf;
        logic [31:0]      f[12];
        case_t            c;
        fd = $fopen("verification/exec_cases.txt", "r");
        if (fd == 0)
        begin
            $display("ERROR: cannot open the case file verification/exec_cases.txt");
            stop_on_error();
        end
        while (!$feof(fd))
        begin
            line_buf = '0;
            got      = $fgets(line_buf, fd);
            n = $sscanf(line_buf, "%h %h %h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2],
                        f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11]);
            if (got > 0 && n == 12)
            begin
                c.ctl.op   = alu_op_e'(f[0][4:0]);
                c.ctl.muxa = muxa_sel_e'(f[1][0]);
                c.ctl.muxb = muxb_sel_e'(f[2][0]);
                c.ctl.fw_a = fw_sel_e'(f[3][1:0]);
                c.ctl.fw_b = fw_sel_e'(f[4][1:0]);
                c.rs       = f[5];
                c.rt       = f[6];
                c.ext      = f[7];
                c.fwd.alu  = f[8];
                c.fwd.mem  = f[9];
                c.exp_a    = f[10];
                c.exp_b    = f[11];
                cases.push_back(c);
            end
            else if (got > 0 && n > 0)
            begin
                $display("ERROR: case file line %0d has too few columns", cases.size() + 1);
                stop_on_error();
            end
        end
        $fclose(fd);
    endtask

    task automatic apply_case(input case_t c);
        ctl_in = c.ctl;
        rs_in  = c.rs;
        rt_in  = c.rt;
        ext_in = c.ext;
        fwd_in = c.fwd;
    endtask

    // codes the unit must ignore while busy
    task automatic drive_busy_op(input int k);
        ctl_in = '0;
        case (k % 3)
            0:       ctl_in.op = OP_MULT;
            1:       ctl_in.op = OP_MTHI;
            default: ctl_in.op = OP_MTLO;
        endcase
        rs_in = next_random();
        rt_in = next_random();
    endtask

    task automatic run_case(input case_t c, input int idx);
        int cycles;
        @(negedge clk);
        apply_case(c);
        #1;
        if (!is_start(c.ctl.op))
        begin
            check_word($sformatf("result_o (case %0d)", idx), c.exp_a, result_o);
            check_word($sformatf("store_data_o (case %0d)", idx), c.exp_b, store_data_o);
        end
        else
        begin
            check_rdy($sformatf("md_rdy_o before start (case %0d)", idx), 1'b1, md_rdy_o);
            cycles = 0;
            @(negedge clk);
            check_rdy($sformatf("md_rdy_o after start (case %0d)", idx), 1'b0, md_rdy_o);
            while (!md_rdy_o)
            begin
                if (cycles >= `EXEC_MD_STEPS + 2)
                begin
                    $display("ERROR: multiply/divide unit still busy after %0d cycles (case %0d)",
                             cycles, idx);
                    stop_on_error();
                end
                drive_busy_op(cycles);
                @(negedge clk);
                cycles++;
            end
            ctl_in    = '0;
            ctl_in.op = OP_MFHI;
            #1;
            check_word($sformatf("hi via result_o (case %0d)", idx), c.exp_a, result_o);
            @(negedge clk);
            ctl_in.op = OP_MFLO;
            #1;
            check_word($sformatf("lo via result_o (case %0d)", idx), c.exp_b, result_o);
        end
    endtask

    initial
    begin
        wait (watchdog_ns > 0);
        #(watchdog_ns);
        $display("ERROR: simulation timed out after %0d ns", watchdog_ns);
        stop_on_error();
    end

    initial
    begin
        case_t c;
        int    k;
        clk         = 1'b0;
        rst         = 1'b0;
        ctl_in      = '0;
        rs_in       = '0;
        rt_in       = '0;
        ext_in      = '0;
        fwd_in      = '0;
        rand_state  = 32'hc667;
        watchdog_ns = 0;

        load_cases();
        watchdog_ns = (cases.size() + RANDOM_CASES) * CYCLES_PER_CASE * CLK_PERIOD_NS;

        repeat (3) @(negedge clk);
        rst = 1'b1;
        #1;
        check_rdy("md_rdy_o after reset", 1'b1, md_rdy_o);

        foreach (cases[i])
            run_case(cases[i], i);

        for (k = 0; k < RANDOM_CASES; k++)
        begin
            c = make_random_case();
            run_case(c, cases.size() + k);
        end

        $display("Test passed");
        $finish;
    end

endmodule

// ==== verification/exec_cases.txt ====
# op muxa muxb fw_a fw_b rs rt ext fwd_alu fwd_mem exp_result exp_store, all hex
# for mult/multu/div/divu (0f..12) the last two columns are expected hi and lo
# op codes: 01 pa 02 pb 03 add 04 sub 05 subu 06 or 07 and 08 xor 09 nor 0a slt 0b sltu
# 0c sll 0d srl 0e sra 0f mult 10 multu 11 div 12 divu 13 mfhi 14 mflo 15 mthi 16 mtlo
13 0 0 0 0 00000000 00000000 00000000 a1a1a1a1 b2b2b2b2 00000000 00000000
14 0 0 0 0 00000000 00000000 00000000 a1a1a1a1 b2b2b2b2 00000000 00000000
01 0 0 0 0 12345678 9abcdef0 00000000 a1a1a1a1 b2b2b2b2 12345678 9abcdef0
02 0 0 0 0 12345678 9abcdef0 00000000 a1a1a1a1 b2b2b2b2 9abcdef0 9abcdef0
03 0 0 0 0 7fffffff 00000001 00000000 a1a1a1a1 b2b2b2b2 80000000 00000001
03 0 1 0 0 00000010 deadbeef 00000020 a1a1a1a1 b2b2b2b2 00000030 deadbeef
04 0 0 0 0 00000005 00000007 00000000 a1a1a1a1 b2b2b2b2 fffffffe 00000007
05 0 0 0 0 80000000 00000001 00000000 a1a1a1a1 b2b2b2b2 7fffffff 00000001
06 0 0 0 0 f0f0f0f0 0f0f00ff 00000000 a1a1a1a1 b2b2b2b2 fffff0ff 0f0f00ff
07 0 0 0 0 f0f0f0f0 ff00ff00 00000000 a1a1a1a1 b2b2b2b2 f000f000 ff00ff00
08 0 0 0 0 ffff0000 0ff00ff0 00000000 a1a1a1a1 b2b2b2b2 f00f0ff0 0ff00ff0
09 0 0 0 0 f0f0f0f0 0f0f0000 00000000 a1a1a1a1 b2b2b2b2 00000f0f 0f0f0000
0a 0 0 0 0 80000000 7fffffff 00000000 a1a1a1a1 b2b2b2b2 00000001 7fffffff
0a 0 0 0 0 7fffffff 80000000 00000000 a1a1a1a1 b2b2b2b2 00000000 80000000
0a 0 0 0 0 ffffffff 00000000 00000000 a1a1a1a1 b2b2b2b2 00000001 00000000
0b 0 0 0 0 ffffffff 00000000 00000000 a1a1a1a1 b2b2b2b2 00000000 00000000
0b 0 0 0 0 00000000 ffffffff 00000000 a1a1a1a1 b2b2b2b2 00000001 ffffffff
0b 0 0 0 0 12345678 12345678 00000000 a1a1a1a1 b2b2b2b2 00000000 12345678
0c 0 0 0 0 00000004 0000000f 00000000 a1a1a1a1 b2b2b2b2 000000f0 0000000f
0c 0 0 0 0 ffffffe1 80000001 00000000 a1a1a1a1 b2b2b2b2 00000002 80000001
0d 0 0 0 0 00000008 80000000 00000000 a1a1a1a1 b2b2b2b2 00800000 80000000
0e 0 0 0 0 00000004 80000000 00000000 a1a1a1a1 b2b2b2b2 f8000000 80000000
0e 0 0 0 0 0000001f fffffff0 00000000 a1a1a1a1 b2b2b2b2 ffffffff fffffff0
03 0 0 1 2 00000001 00000002 00000000 a1a1a1a1 b2b2b2b2 54545453 b2b2b2b2
02 0 1 0 1 11111111 22222222 33333333 a1a1a1a1 b2b2b2b2 33333333 a1a1a1a1
01 1 0 2 0 11111111 22222222 44444444 a1a1a1a1 b2b2b2b2 44444444 22222222
01 0 0 2 0 11111111 22222222 00000000 a1a1a1a1 b2b2b2b2 b2b2b2b2 22222222
15 0 0 0 0 cafef00d 00000000 00000000 a1a1a1a1 b2b2b2b2 00000000 00000000
16 0 0 0 0 0badf00d 00000007 00000000 a1a1a1a1 b2b2b2b2 00000000 00000007
13 0 0 0 0 00000000 00000000 00000000 a1a1a1a1 b2b2b2b2 cafef00d 00000000
14 0 0 0 0 00000000 00000000 00000000 a1a1a1a1 b2b2b2b2 0badf00d 00000000
0f 0 0 0 0 fffffffd 00000007 00000000 a1a1a1a1 b2b2b2b2 ffffffff ffffffeb
10 0 0 0 0 ffffffff ffffffff 00000000 a1a1a1a1 b2b2b2b2 fffffffe 00000001
0f 0 0 0 0 80000000 80000000 00000000 a1a1a1a1 b2b2b2b2 40000000 00000000
0f 0 0 0 0 00012345 00006789 00000000 a1a1a1a1 b2b2b2b2 00000000 75cca2ed
11 0 0 0 0 fffffff9 00000002 00000000 a1a1a1a1 b2b2b2b2 ffffffff fffffffd
12 0 0 0 0 00000064 00000007 00000000 a1a1a1a1 b2b2b2b2 00000002 0000000e
11 0 0 0 0 00000064 fffffff9 00000000 a1a1a1a1 b2b2b2b2 00000002 fffffff2
12 0 0 0 0 ffffffff 00000010 00000000 a1a1a1a1 b2b2b2b2 0000000f 0fffffff
11 0 0 0 0 80000000 00000003 00000000 a1a1a1a1 b2b2b2b2 fffffffe d5555556

// ==== verilog.f ====
+incdir+hdl
hdl/exec_pkg.sv
hdl/exec_operand_sel.sv
hdl/exec_alu.sv
hdl/exec_muldiv.sv
hdl/exec_stage.sv
verification/exec_stage_tb.sv

// ==== Makefile ====
# Verilator build of the execute stage testbench

TOOL     = verilator
FLAGS    = --binary --timing -j 0 -Wno-fatal
TOP      = exec_stage_tb
FILELIST = verilog.f
OBJ_DIR  = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the simulation runs from the project root so the case file path resolves
run: compile
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Test passed"

clean:
	rm -rf $(OBJ_DIR)
